/* src.f */
hw/IssuePkg.sv
hw/ReservationStation.sv
hw/AluUnit.sv
hw/MulUnit.sv
hw/ResultArbiter.sv
hw/IssueCore.sv
bench/IssueCore_props.sv
bench/IssueCoreTb.sv

/* run.sh */
#!/bin/bash
# build and run the issue core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module IssueCoreTb \
    -f src.f --Mdir obj_dir -o simv > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* bench/IssueCoreTb.sv */
module IssueCoreTb
    import IssuePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OPS = 30;
    localparam int PHASE_B = 20;
    localparam int FLUSH_AT = 24;
    localparam int LIMIT = 4 * NUM_OPS + 200;

    logic           clk = 1'b0;
    logic           rst;
    logic           dispatchValid;
    MicroOp         dispatchUop;
    logic           flushValid;
    logic [5:0]     flushSqN;
    logic           resultValid;
    ResultBus       result;
    logic [3:0]     freeCount;

    logic [31:0]    lfsr = 32'h7598;
    logic [15:0]    expVal [32];
    logic [5:0]     expSqN [32];
    bit             issuedTag [32];
    bit             doneTag [32];
    bit             killedTag [32];
    bit             passed = 0;
    bit             failReported = 0;
    int             cycles = 0;

    IssueCore #(.DEPTH(8)) UUT (.*);

    always #2 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [15:0] applyOp(input OpCode op, input logic [15:0] a,
                                            input logic [15:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    function automatic int outstanding();
        int cnt;
        cnt = 0;
        for (int t = 1; t <= NUM_OPS; t++) begin
            if (issuedTag[t] && !doneTag[t] && !killedTag[t]) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    task automatic stopWithFail();
        $display("Test failed");
        failReported = 1;
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [15:0] exp,
                                  input logic [15:0] got);
        $display("FAILED %s expected %h got %h", name, exp, got);
        stopWithFail();
    endtask

    // a source either depends on a recent op of this phase or is an immediate
    task automatic makeSource(input int n, input int phaseStart, output logic [4:0] tag,
                              output logic avail, output logic [15:0] val,
                              output logic [15:0] expected);
        int p;
        tag = '0;
        avail = 1'b1;
        val = randBits(16);
        expected = val;
        if (n > phaseStart && randBits(2) < 16'd2) begin
            p = n - 1 - int'(randBits(2));
            if (p < phaseStart) begin
                p = phaseStart;
            end
            tag = 5'(p + 1);
            expected = expVal[tag];
            avail = doneTag[tag];
            val = avail ? expected : 16'hdead;
        end
    endtask

    task automatic runPhase(input int first, input int last);
        int n;
        MicroOp u;
        logic [15:0] r;
        logic [15:0] ea;
        logic [15:0] eb;
        n = first;
        while (n < last) begin
            @(posedge clk);
            if (freeCount >= 4'd2 && randBits(1) != 16'd0) begin
                r = randBits(2);
                u.op = OpCode'(r[1:0]);
                u.sqN = 6'(n);
                u.tagDst = 5'(n + 1);
                makeSource(n, first, u.tagA, u.availA, u.valA, ea);
                makeSource(n, first, u.tagB, u.availB, u.valB, eb);
                expVal[n+1] = applyOp(u.op, ea, eb);
                expSqN[n+1] = 6'(n);
                issuedTag[n+1] = 1;
                dispatchValid <= 1'b1;
                dispatchUop <= u;
                n++;
            end else begin
                dispatchValid <= 1'b0;
            end
        end
    endtask

    task automatic waitDrain();
        while (outstanding() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        assert (freeCount == 4'd8) else begin
            $display("FAILED freeCount expected %h got %h", 4'd8, freeCount);
            stopWithFail();
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles == LIMIT) begin
            $display("timeout: results still missing after %0d cycles", cycles);
            stopWithFail();
        end
    end

    // results are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!rst && resultValid) begin
            assert (issuedTag[result.tagDst] && !doneTag[result.tagDst] &&
                    !killedTag[result.tagDst]) else begin
                $display("unexpected, repeated or flushed result on tag %0d", result.tagDst);
                stopWithFail();
            end
            assert (result.value == expVal[result.tagDst]) else
                reportMismatch("result.value", expVal[result.tagDst], result.value);
            assert (result.sqN == expSqN[result.tagDst]) else
                reportMismatch("result.sqN", 16'(expSqN[result.tagDst]), 16'(result.sqN));
            doneTag[result.tagDst] = 1;
        end
    end

    initial begin
        rst = 1'b1;
        dispatchValid = 1'b0;
        dispatchUop = '0;
        flushValid = 1'b0;
        flushSqN = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (!resultValid) else
            reportMismatch("resultValid", 16'd0, 16'(resultValid));
        assert (freeCount == 4'd8) else
            reportMismatch("freeCount", 16'd8, 16'(freeCount));

        runPhase(0, PHASE_B);
        @(posedge clk);
        dispatchValid <= 1'b0;
        waitDrain();

        // younger ops still in flight when the flush hits
        runPhase(PHASE_B, NUM_OPS);
        @(posedge clk);
        dispatchValid <= 1'b0;
        flushValid <= 1'b1;
        flushSqN <= 6'(FLUSH_AT);
        @(posedge clk);
        flushValid <= 1'b0;
        for (int t = FLUSH_AT + 2; t <= NUM_OPS; t++) begin
            if (!doneTag[t]) begin
                killedTag[t] = 1;
            end
        end
        waitDrain();

        passed = 1;
        $display("Test passed");
        $finish;
    end

    final begin
        if (!passed && !failReported) begin
            $display("Test failed");
        end
    end

endmodule

/* bench/IssueCore_props.sv */
module IssueCoreProps
    import IssuePkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dispatchValid,
    input  logic                        flushValid,
    input  logic [SQN_W-1:0]            flushSqN,
    input  logic                        resultValid,
    input  ResultBus                    result,
    input  logic [$clog2(DEPTH+1)-1:0]  freeCount,
    input  logic                        aluIssueValid,
    input  logic                        mulIssueValid,
    input  logic                        aluDoneValid,
    input  ResultBus                    aluDone,
    input  logic                        mulDoneValid,
    input  logic                        aluStall
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FREE_W = $clog2(DEPTH + 1);

    // a refused ALU keeps its result unchanged for a later cycle
    aluHeldOnConflict: assert property (@(posedge clk) disable iff (rst)
        (aluDoneValid && mulDoneValid && !flushValid) |=> (aluDoneValid && $stable(aluDone)))
        else $error("ALU result lost or changed while the multiplier held the bus");

    // one slot taken per dispatch, one given back per issue on either port
    freeTrack: assert property (@(posedge clk) disable iff (rst)
        !flushValid |=> int'(freeCount) == int'($past(freeCount)) - int'($past(dispatchValid))
            + int'(mulIssueValid) + int'(aluIssueValid && !$past(aluStall)))
        else $error("free count does not follow dispatches and issues");

    // nothing younger than the flush point right after the flush edge
    flushKills: assert property (@(posedge clk) disable iff (rst)
        flushValid |=> !(resultValid && $signed(result.sqN - $past(flushSqN)) > 0))
        else $error("result younger than the flush point after a flush");

    resetState: assert property (@(posedge clk)
        rst |=> (!resultValid && freeCount == FREE_W'(DEPTH)))
        else $error("core not idle after reset");

endmodule

bind IssueCore IssueCoreProps #(.DEPTH(DEPTH)) props (.*);

/* hw/IssueCore.sv */
module IssueCore
    import IssuePkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dispatchValid,
    input  MicroOp                      dispatchUop,
    input  logic                        flushValid,
    input  logic [SQN_W-1:0]            flushSqN,
    output logic                        resultValid,
    output ResultBus                    result,
    output logic [$clog2(DEPTH+1)-1:0]  freeCount
);

    logic       aluIssueValid;
    IssuedOp    aluIssue;
    logic       mulIssueValid;
    IssuedOp    mulIssue;
    logic       aluDoneValid;
    ResultBus   aluDone;
    logic       mulDoneValid;
    ResultBus   mulDone;
    logic       aluStall;

    ReservationStation #(
        .DEPTH(DEPTH)
    ) rs (
        .clk(clk),
        .rst(rst),
        .dispatchValid(dispatchValid),
        .dispatchUop(dispatchUop),
        .wakeValid(resultValid),
        .wakeBus(result),
        .flushValid(flushValid),
        .flushSqN(flushSqN),
        .aluStall(aluStall),
        .aluIssueValid(aluIssueValid),
        .aluIssue(aluIssue),
        .mulIssueValid(mulIssueValid),
        .mulIssue(mulIssue),
        .freeCount(freeCount)
    );

    AluUnit alu (
        .clk(clk),
        .rst(rst),
        .issueValid(aluIssueValid),
        .issue(aluIssue),
        .stall(aluStall),
        .flushValid(flushValid),
        .flushSqN(flushSqN),
        .doneValid(aluDoneValid),
        .done(aluDone)
    );

    MulUnit mul (
        .clk(clk),
        .rst(rst),
        .issueValid(mulIssueValid),
        .issue(mulIssue),
        .flushValid(flushValid),
        .flushSqN(flushSqN),
        .doneValid(mulDoneValid),
        .done(mulDone)
    );

    ResultArbiter arb (
        .aluValid(aluDoneValid),
        .aluResult(aluDone),
        .mulValid(mulDoneValid),
        .mulResult(mulDone),
        .busValid(resultValid),
        .bus(result),
        .aluStall(aluStall)
    );

endmodule

/* hw/ResultArbiter.sv */
module ResultArbiter
    import IssuePkg::*;
(
    input  logic        aluValid,
    input  ResultBus    aluResult,
    input  logic        mulValid,
    input  ResultBus    mulResult,
    output logic        busValid,
    output ResultBus    bus,
    output logic        aluStall
);

    // the multiplier cannot wait, its pipeline has no hold
    always_comb begin
        busValid = aluValid || mulValid;
        if (mulValid) begin
            bus = mulResult;
        end else begin
            bus = aluResult;
        end
    end

    // ALU refused whenever both ask in the same cycle
    assign aluStall = aluValid && mulValid;

endmodule

/* hw/MulUnit.sv */
module MulUnit
    import IssuePkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                issueValid,
    input  IssuedOp             issue,
    input  logic                flushValid,
    input  logic [SQN_W-1:0]    flushSqN,
    output logic                doneValid,
    output ResultBus            done
);

    // partial products, only the low 16 bits of the full product are kept
    typedef struct packed {
        logic [TAG_W-1:0]       tagDst;
        logic [SQN_W-1:0]       sqN;
        logic [DATA_W-1:0]      partLo;
        logic [DATA_W/2-1:0]    partHi;
    } MulPartial;

    IssuedOp    s1;
    MulPartial  s2;
    logic       s1Valid;
    logic       s2Valid;

    function automatic logic killed(input logic flush, input logic [SQN_W-1:0] flushSq,
                                    input logic [SQN_W-1:0] sqN);
        return flush && isYounger(sqN, flushSq);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            doneValid <= 1'b0;
        end else begin
            s1Valid <= issueValid && !killed(flushValid, flushSqN, issue.sqN);
            s2Valid <= s1Valid && !killed(flushValid, flushSqN, s1.sqN);
            doneValid <= s2Valid && !killed(flushValid, flushSqN, s2.sqN);
        end
    end

    always_ff @(posedge clk) begin
        s1 <= issue;
        s2.tagDst <= s1.tagDst;
        s2.sqN <= s1.sqN;
        s2.partLo <= s1.a * s1.b[DATA_W/2-1:0];
        s2.partHi <= s1.a[DATA_W/2-1:0] * s1.b[DATA_W-1:DATA_W/2];
        done.tagDst <= s2.tagDst;
        done.sqN <= s2.sqN;
        done.value <= s2.partLo + {s2.partHi, {(DATA_W/2){1'b0}}};
    end

endmodule

/* hw/AluUnit.sv */
module AluUnit
    import IssuePkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                issueValid,
    input  IssuedOp             issue,
    input  logic                stall,
    input  logic                flushValid,
    input  logic [SQN_W-1:0]    flushSqN,
    output logic                doneValid,
    output ResultBus            done
);

    logic [DATA_W-1:0] aluValue;

    always_comb begin
        case (issue.op)
            OP_ADD:  aluValue = issue.a + issue.b;
            OP_SUB:  aluValue = issue.a - issue.b;
            OP_XOR:  aluValue = issue.a ^ issue.b;
            default: aluValue = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            doneValid <= 1'b0;
        end else if (stall) begin
            // refused by the arbiter, hold unless flushed away
            doneValid <= doneValid && !(flushValid && isYounger(done.sqN, flushSqN));
        end else begin
            doneValid <= issueValid && !(flushValid && isYounger(issue.sqN, flushSqN));
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            done <= '{tagDst: issue.tagDst, sqN: issue.sqN, value: aluValue};
        end
    end

endmodule

/* hw/ReservationStation.sv */
module ReservationStation
    import IssuePkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dispatchValid,
    input  MicroOp                      dispatchUop,
    input  logic                        wakeValid,
    input  ResultBus                    wakeBus,
    input  logic                        flushValid,
    input  logic [SQN_W-1:0]            flushSqN,
    input  logic                        aluStall,
    output logic                        aluIssueValid,
    output IssuedOp                     aluIssue,
    output logic                        mulIssueValid,
    output IssuedOp                     mulIssue,
    output logic [$clog2(DEPTH+1)-1:0]  freeCount
);

    localparam int IDX_W  = $clog2(DEPTH);
    localparam int FREE_W = $clog2(DEPTH + 1);

    MicroOp             entries [DEPTH];
    logic [DEPTH-1:0]   entryValid;
    logic [DEPTH-1:0]   validNext;
    logic [SQN_W-1:0]   entrySqN [DEPTH];
    logic [DEPTH-1:0]   aluReady;
    logic [DEPTH-1:0]   mulReady;
    logic [IDX_W-1:0]   insIdx;
    logic [IDX_W-1:0]   aluIdx;
    logic [IDX_W-1:0]   mulIdx;
    logic               aluPickValid;
    logic               mulPickValid;
    logic               aluGo;
    logic               mulGo;
    MicroOp             insUop;

    function automatic logic tagHit(input logic valid, input ResultBus bus,
                                    input logic [TAG_W-1:0] tag);
        return valid && bus.tagDst != '0 && bus.tagDst == tag;
    endfunction

    function automatic IssuedOp toIssued(input MicroOp u);
        return '{op: u.op, sqN: u.sqN, tagDst: u.tagDst, a: u.valA, b: u.valB};
    endfunction

    // heap of oldest-of-two nodes, leaves at DEPTH..2*DEPTH-1, root at 1
    function automatic logic [IDX_W:0] pickOldest(input logic [DEPTH-1:0] ready,
                                                  input logic [SQN_W-1:0] sqns [DEPTH]);
        logic               nodeValid [2*DEPTH];
        logic [IDX_W-1:0]   nodeIdx [2*DEPTH];
        logic [SQN_W-1:0]   nodeSqN [2*DEPTH];
        logic               takeLeft;
        nodeValid[0] = 1'b0;
        nodeIdx[0] = '0;
        nodeSqN[0] = '0;
        for (int j = 0; j < DEPTH; j++) begin
            nodeValid[DEPTH+j] = ready[j];
            nodeIdx[DEPTH+j] = IDX_W'(j);
            nodeSqN[DEPTH+j] = sqns[j];
        end
        for (int n = DEPTH - 1; n >= 1; n--) begin
            takeLeft = nodeValid[2*n] &&
                (!nodeValid[2*n+1] || isYounger(nodeSqN[2*n+1], nodeSqN[2*n]));
            nodeValid[n] = nodeValid[2*n] || nodeValid[2*n+1];
            nodeIdx[n] = takeLeft ? nodeIdx[2*n] : nodeIdx[2*n+1];
            nodeSqN[n] = takeLeft ? nodeSqN[2*n] : nodeSqN[2*n+1];
        end
        return {nodeValid[1], nodeIdx[1]};
    endfunction

    // lowest free slot
    always_comb begin
        insIdx = '0;
        for (int j = DEPTH - 1; j >= 0; j--) begin
            if (!entryValid[j]) begin
                insIdx = IDX_W'(j);
            end
        end
    end

    // a result on the bus in the dispatch cycle is caught here
    always_comb begin
        insUop = dispatchUop;
        if (!dispatchUop.availA && tagHit(wakeValid, wakeBus, dispatchUop.tagA)) begin
            insUop.availA = 1'b1;
            insUop.valA = wakeBus.value;
        end
        if (!dispatchUop.availB && tagHit(wakeValid, wakeBus, dispatchUop.tagB)) begin
            insUop.availB = 1'b1;
            insUop.valB = wakeBus.value;
        end
    end

    always_comb begin
        for (int j = 0; j < DEPTH; j++) begin
            entrySqN[j] = entries[j].sqN;
            aluReady[j] = entryValid[j] && entries[j].availA && entries[j].availB &&
                !isMulOp(entries[j].op);
            mulReady[j] = entryValid[j] && entries[j].availA && entries[j].availB &&
                isMulOp(entries[j].op);
        end
        {aluPickValid, aluIdx} = pickOldest(aluReady, entrySqN);
        {mulPickValid, mulIdx} = pickOldest(mulReady, entrySqN);
    end

    assign aluGo = aluPickValid && !aluStall && !flushValid;
    assign mulGo = mulPickValid && !flushValid;

    always_comb begin
        validNext = entryValid;
        if (flushValid) begin
            for (int j = 0; j < DEPTH; j++) begin
                if (isYounger(entries[j].sqN, flushSqN)) begin
                    validNext[j] = 1'b0;
                end
            end
        end else begin
            if (aluGo) begin
                validNext[aluIdx] = 1'b0;
            end
            if (mulGo) begin
                validNext[mulIdx] = 1'b0;
            end
            if (dispatchValid) begin
                validNext[insIdx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            freeCount <= FREE_W'(DEPTH);
            aluIssueValid <= 1'b0;
            mulIssueValid <= 1'b0;
        end else begin
            entryValid <= validNext;
            freeCount <= FREE_W'(DEPTH - $countones(validNext));
            mulIssueValid <= mulGo;
            // a stalled port 0 keeps its op until the ALU takes it
            if (aluStall) begin
                aluIssueValid <= aluIssueValid &&
                    !(flushValid && isYounger(aluIssue.sqN, flushSqN));
            end else begin
                aluIssueValid <= aluGo;
            end
        end
    end

    always_ff @(posedge clk) begin
        // captured even in a flush cycle, so older waiters keep their producer
        for (int j = 0; j < DEPTH; j++) begin
            if (!entries[j].availA && tagHit(wakeValid, wakeBus, entries[j].tagA)) begin
                entries[j].availA <= 1'b1;
                entries[j].valA <= wakeBus.value;
            end
            if (!entries[j].availB && tagHit(wakeValid, wakeBus, entries[j].tagB)) begin
                entries[j].availB <= 1'b1;
                entries[j].valB <= wakeBus.value;
            end
        end
        if (dispatchValid && !flushValid) begin
            entries[insIdx] <= insUop;
        end
        if (aluGo) begin
            aluIssue <= toIssued(entries[aluIdx]);
        end
        if (mulGo) begin
            mulIssue <= toIssued(entries[mulIdx]);
        end
    end

endmodule

/* hw/IssuePkg.sv */
package IssuePkg;

    localparam int TAG_W  = 5;
    localparam int SQN_W  = 6;
    localparam int DATA_W = 16;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_MUL = 2'd3
    } OpCode;

    // renamed op as it leaves dispatch
    typedef struct packed {
        OpCode              op;
        logic [SQN_W-1:0]   sqN;
        logic [TAG_W-1:0]   tagDst;
        logic [TAG_W-1:0]   tagA;
        logic               availA;
        logic [DATA_W-1:0]  valA;
        logic [TAG_W-1:0]   tagB;
        logic               availB;
        logic [DATA_W-1:0]  valB;
    } MicroOp;

    typedef struct packed {
        OpCode              op;
        logic [SQN_W-1:0]   sqN;
        logic [TAG_W-1:0]   tagDst;
        logic [DATA_W-1:0]  a;
        logic [DATA_W-1:0]  b;
    } IssuedOp;

    typedef struct packed {
        logic [TAG_W-1:0]   tagDst;
        logic [SQN_W-1:0]   sqN;
        logic [DATA_W-1:0]  value;
    } ResultBus;

    function automatic logic isMulOp(input OpCode op);
        return op == OP_MUL;
    endfunction

    // true when a comes after b in program order, sequence numbers wrap
    function automatic logic isYounger(input logic [SQN_W-1:0] a, input logic [SQN_W-1:0] b);
        logic signed [SQN_W-1:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

endpackage
